// ==== Makefile ====
# Verilator build and run of the MMIO testbench

VERILATOR ?= verilator
TOP       ?= mmio_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/data_sram.sv ====
`timescale 1ns/10ps

module data_sram (
    input  logic               clk,
    input  logic               nrst,
    input  mmio_pkg::mem_req_s mem_req, // strobes, tagged address, store data
    output mmio_pkg::word_t    rdata,   // valid once busy_o drops
    output logic               busy_o   // access in progress
);
    import mmio_pkg::*;

    word_t                 mem [SRAM_WORDS]; // shared instr and data words
    logic                  tag_ok;           // address carries bus tag
    logic                  start;            // accepted strobe
    logic                  done;             // last busy cycle
    logic                  rd_q;             // pending load or fetch
    logic                  wr_q;             // pending store
    sram_addr_t            idx_q;
    word_t                 wdata_q;
    logic [SRAM_CNT_W-1:0] lat_cnt;          // busy cycles left

    assign tag_ok = (mem_req.addr[31:24] == BUS_TAG);
    assign start  = ~busy_o & tag_ok & (mem_req.read | mem_req.write);
    assign done   = busy_o & (lat_cnt == '0);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            busy_o  <= 1'b0;
            lat_cnt <= '0;
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
        end else if (start) begin
            busy_o  <= 1'b1;
            lat_cnt <= SRAM_CNT_W'(SRAM_LAT - 1);
            rd_q    <= mem_req.read;
            wr_q    <= mem_req.write;
        end else if (done) begin
            busy_o <= 1'b0;              // falls, access completes here
            rd_q   <= 1'b0;
            wr_q   <= 1'b0;
        end else if (busy_o) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    // latch the access at the strobe
    always_ff @(posedge clk) begin
        if (start) begin
            idx_q   <= mem_req.addr[9:2]; // word index
            wdata_q <= mem_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (done && wr_q) begin
            mem[idx_q] <= wdata_q;
        end
        if (done && rd_q) begin
            rdata <= mem[idx_q];          // held until next load
        end
    end

    // router always prepends the tag
    a_tag : assert property (
        @(posedge clk) disable iff (!nrst)
        (mem_req.read || mem_req.write) |-> tag_ok
    );

    // fixed latency per access
    a_latency : assert property (
        @(posedge clk) disable iff (!nrst)
        start |=> busy_o [*SRAM_LAT] ##1 !busy_o
    );

endmodule

// ==== design/ext_reg_bank.sv ====
`timescale 1ns/10ps

module ext_reg_bank (
    input  logic                clk,
    input  logic                nrst,
    input  logic                esp_wr,    // esp32 write strobe
    input  mmio_pkg::reg_addr_t esp_addr,
    input  mmio_pkg::word_t     esp_data,
    input  logic                reg_read,  // router read level
    input  mmio_pkg::reg_addr_t reg_addr,
    output mmio_pkg::word_t     reg_data,  // straight from the array
    output logic                chip_sel,  // readable when high
    output logic                ack        // one cycle per read
);
    import mmio_pkg::*;

    word_t regs [32];  // esp32 mailbox registers
    logic  acked_q;    // ack already given for this read

    assign chip_sel = ~esp_wr;          // block reads during esp write
    assign reg_data = regs[reg_addr];
    assign ack      = reg_read & chip_sel & ~acked_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (esp_wr) begin
            regs[esp_addr] <= esp_data;
        end
    end

    // set by the ack cycle, cleared once reg_read drops
    always_ff @(posedge clk) begin
        if (!nrst) begin
            acked_q <= 1'b0;
        end else begin
            acked_q <= reg_read & (acked_q | chip_sel);
        end
    end

endmodule

// ==== design/mmio_pkg.sv ====
package mmio_pkg;

    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_addr_t;  // external register index
    typedef logic [7:0]  sram_addr_t; // sram word index

    typedef enum logic [1:0] {
        req_idle  = 2'b00,
        req_write = 2'b01,
        req_read  = 2'b10,
        req_fetch = 2'b11
    } req_t;

    // inclusive upper bound of each region
    localparam word_t INSTR_TOP = 32'd1024;
    localparam word_t REG_TOP   = 32'd1056;
    localparam word_t DATA_TOP  = 32'd1792;
    localparam word_t TFT_TOP   = 32'd1800;

    localparam logic [7:0] BUS_TAG = 8'h33;        // addr[31:24] toward memory
    localparam int SRAM_LAT        = 3;            // busy cycles per access
    localparam int SRAM_CNT_W      = $clog2(SRAM_LAT);
    localparam int SRAM_WORDS      = 256;
    localparam int TFT_BITS        = 32;           // bits per tft frame

    typedef struct packed {
        word_t addr;
        req_t  rwi;   // idle / write / read / fetch
        word_t wdata; // store data
    } cpu_req_s;

    typedef struct packed {
        word_t rdata; // load data
        word_t instr; // fetched instruction
        logic  busy;  // hold request while high
    } cpu_rsp_s;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;  // tagged bus address
        word_t wdata;
    } mem_req_s;

    typedef struct packed {
        logic  wi;    // one-cycle write strobe
        word_t addr;
        word_t data;
    } tft_req_s;

endpackage

// ==== design/mmio_router.sv ====
`timescale 1ns/10ps

module mmio_router (
    input  logic                clk,
    input  logic                nrst,
    input  mmio_pkg::cpu_req_s  cpu_req,   // request from cpu memory handler
    input  mmio_pkg::word_t     mem_rdata, // registered sram data
    input  logic                busy_o,    // sram access running
    input  mmio_pkg::word_t     reg_data,  // external register contents
    input  logic                chip_sel,  // low while esp32 writes
    input  logic                ack,       // first cycle of a register read
    input  logic                ack_tft,   // tft frame still shifting
    output mmio_pkg::cpu_rsp_s  cpu_rsp,
    output mmio_pkg::mem_req_s  mem_req,
    output logic                reg_read,
    output mmio_pkg::reg_addr_t reg_addr,
    output mmio_pkg::tft_req_s  tft_req
);
    import mmio_pkg::*;

    logic in_instr;   // fetch region
    logic in_reg;     // external registers
    logic in_data;    // data memory
    logic in_tft;     // tft write port
    logic is_fetch;
    logic is_read;
    logic is_write;
    logic busy_q;     // busy one cycle back
    logic start_ok;   // first cycle of a new request
    logic mem_rd;
    logic mem_wr;
    logic tft_wr;
    logic reg_rd;     // register read in progress
    logic reg_busy;
    logic busy;

    // region decode
    assign in_instr = (cpu_req.addr <= INSTR_TOP);
    assign in_reg   = (cpu_req.addr > INSTR_TOP) && (cpu_req.addr <= REG_TOP);
    assign in_data  = (cpu_req.addr > REG_TOP) && (cpu_req.addr <= DATA_TOP);
    assign in_tft   = (cpu_req.addr > DATA_TOP) && (cpu_req.addr <= TFT_TOP);

    assign is_fetch = (cpu_req.rwi == req_fetch);
    assign is_read  = (cpu_req.rwi == req_read);
    assign is_write = (cpu_req.rwi == req_write);

    // strobes only fire while busy_q is low, so the cycle after busy
    // falls never restarts the request the cpu is still holding
    assign start_ok = ~busy_q;

    assign mem_rd = start_ok & ((is_fetch & in_instr) | (is_read & in_data));
    assign mem_wr = start_ok & is_write & in_data;
    assign tft_wr = start_ok & is_write & in_tft;

    assign reg_rd   = is_read & in_reg;
    assign reg_busy = reg_rd & (~chip_sel | ack); // stall on esp write, then one ack cycle

    // start term covers the cycle before the target answers
    assign busy = busy_o | ack_tft | reg_busy | mem_rd | mem_wr | tft_wr;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= busy;
        end
    end

    always_comb begin
        mem_req       = '0;                                // defaults first
        mem_req.read  = mem_rd;
        mem_req.write = mem_wr;
        mem_req.addr  = {BUS_TAG, cpu_req.addr[23:0]};     // tag upper byte
        mem_req.wdata = cpu_req.wdata;

        tft_req      = '0;
        tft_req.wi   = tft_wr;
        tft_req.addr = cpu_req.addr;
        tft_req.data = cpu_req.wdata;

        reg_read = reg_rd;
        reg_addr = cpu_req.addr[4:0];                      // word within bank
    end

    // read data steering
    always_comb begin
        cpu_rsp       = '0;
        cpu_rsp.busy  = busy;
        if (reg_rd) begin
            cpu_rsp.rdata = reg_data;                      // combinational from bank
        end else if (is_read && in_data) begin
            cpu_rsp.rdata = mem_rdata;                     // load
        end
        if (is_fetch && in_instr) begin
            cpu_rsp.instr = mem_rdata;                     // instruction word
        end
    end

    // strobes only reach an idle sram
    a_strobe_idle : assert property (
        @(posedge clk) disable iff (!nrst)
        (mem_req.read || mem_req.write) |-> !busy_o
    );

    // fresh read with the bank free is acked at once
    a_reg_ack : assert property (
        @(posedge clk) disable iff (!nrst)
        ($rose(reg_read) && chip_sel) |-> ack
    );

endmodule

// ==== design/mmio_top.sv ====
`timescale 1ns/10ps

module mmio_top (
    input  logic                clk,
    input  logic                nrst,
    input  mmio_pkg::cpu_req_s  cpu_req,  // driven by the cpu
    input  logic                esp_wr,   // esp32 register write
    input  mmio_pkg::reg_addr_t esp_addr,
    input  mmio_pkg::word_t     esp_data,
    output mmio_pkg::cpu_rsp_s  cpu_rsp,
    output logic                tft_sclk,
    output logic                tft_mosi,
    output logic                tft_cs_n
);
    import mmio_pkg::*;

    mem_req_s  mem_req;    // router to sram
    word_t     mem_rdata;
    logic      busy_o;
    word_t     reg_data;   // bank to router
    logic      chip_sel;
    logic      ack;
    logic      reg_read;
    reg_addr_t reg_addr;
    tft_req_s  tft_req;    // router to tft writer
    logic      ack_tft;

    mmio_router u_router (
        .clk       (clk),
        .nrst      (nrst),
        .cpu_req   (cpu_req),
        .mem_rdata (mem_rdata),
        .busy_o    (busy_o),
        .reg_data  (reg_data),
        .chip_sel  (chip_sel),
        .ack       (ack),
        .ack_tft   (ack_tft),
        .cpu_rsp   (cpu_rsp),
        .mem_req   (mem_req),
        .reg_read  (reg_read),
        .reg_addr  (reg_addr),
        .tft_req   (tft_req)
    );

    data_sram u_sram (         // instr and data share one array
        .clk     (clk),
        .nrst    (nrst),
        .mem_req (mem_req),
        .rdata   (mem_rdata),
        .busy_o  (busy_o)
    );

    ext_reg_bank u_regs (
        .clk      (clk),
        .nrst     (nrst),
        .esp_wr   (esp_wr),
        .esp_addr (esp_addr),
        .esp_data (esp_data),
        .reg_read (reg_read),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .chip_sel (chip_sel),
        .ack      (ack)
    );

    tft_spi_writer u_tft (
        .clk      (clk),
        .nrst     (nrst),
        .tft_req  (tft_req),
        .ack_tft  (ack_tft),
        .tft_sclk (tft_sclk),
        .tft_mosi (tft_mosi),
        .tft_cs_n (tft_cs_n)
    );

endmodule

// ==== design/tft_spi_writer.sv ====
`timescale 1ns/10ps

module tft_spi_writer (
    input  logic               clk,
    input  logic               nrst,
    input  mmio_pkg::tft_req_s tft_req, // write strobe and payload
    output logic               ack_tft,  // high for the whole frame
    output logic               tft_sclk,
    output logic               tft_mosi, // msb first
    output logic               tft_cs_n
);
    import mmio_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_setup,  // cs low, first bit on mosi
        st_shift,  // two clk per bit
        st_hold    // last bit settles before cs rises
    } tft_state_t;

    tft_state_t                    state;
    logic [$clog2(TFT_BITS)-1:0]   bit_cnt;
    word_t                         shreg;   // frame shift register

    assign tft_mosi = shreg[31] & ~tft_cs_n;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state    <= st_idle;
            ack_tft  <= 1'b0;
            tft_cs_n <= 1'b1;
            tft_sclk <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                st_idle: if (tft_req.wi) begin
                    state    <= st_setup;
                    ack_tft  <= 1'b1;
                    tft_cs_n <= 1'b0;
                end
                st_setup: begin
                    state    <= st_shift;
                    tft_sclk <= 1'b1;                // rising, bit 31 sampled
                    bit_cnt  <= '0;
                end
                st_shift: if (tft_sclk) begin
                    tft_sclk <= 1'b0;                // falling, next bit out
                end else if (bit_cnt == $bits(bit_cnt)'(TFT_BITS - 1)) begin
                    state <= st_hold;
                end else begin
                    tft_sclk <= 1'b1;
                    bit_cnt  <= bit_cnt + 1'b1;
                end
                default: begin
                    state    <= st_idle;
                    ack_tft  <= 1'b0;
                    tft_cs_n <= 1'b1;
                end
            endcase
        end
    end

    // shift register holds the frame, moves on each falling sclk
    always_ff @(posedge clk) begin
        if (state == st_idle && tft_req.wi) begin
            shreg <= tft_req.data;
        end else if (state == st_shift && tft_sclk) begin
            shreg <= {shreg[30:0], 1'b0};
        end
    end

    a_cs_idle : assert property (
        @(posedge clk) disable iff (!nrst)
        (state == st_idle) |-> tft_cs_n
    );

endmodule

// ==== list.f ====
+incdir+testbench
design/mmio_pkg.sv
design/mmio_router.sv
design/data_sram.sv
design/ext_reg_bank.sv
design/tft_spi_writer.sv
design/mmio_top.sv
testbench/mmio_tb.sv

// ==== testbench/mmio_model.svh ====
// reference state seen from the cpu side
word_t sram_model [256];       // shared instr/data words, index addr[9:2]
word_t reg_model  [32];        // esp32 register bank
word_t tft_frames [$];         // frames rebuilt from the tft pins
word_t tft_shift;              // frame being assembled
int    tft_bits   = 0;
logic  sclk_q     = 1'b0;      // sclk one clk back
int    checks     = 0;
int    errors     = 0;

// both regions reach the sram by bits 9:2
function automatic word_t expected_load(input word_t addr);
    return sram_model[addr[9:2]];
endfunction

// register window wraps on the low five bits
function automatic word_t expected_reg(input word_t addr);
    return reg_model[addr[4:0]];
endfunction

// called every clk edge with pre-edge pin values
task automatic capture_tft(input logic sclk, input logic mosi, input logic cs_n);
    if (cs_n) begin
        tft_bits = 0;                                // between frames
    end else if (sclk && !sclk_q) begin
        tft_shift = {tft_shift[30:0], mosi};         // msb arrives first
        tft_bits++;
        if (tft_bits == TFT_BITS) begin
            tft_frames.push_back(tft_shift);
            tft_bits = 0;
        end
    end
    sclk_q = sclk;
endtask

task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

// ==== testbench/mmio_tb.sv ====
`timescale 1ns/10ps

module mmio_tb;
    import mmio_pkg::*;

    localparam int TIMEOUT  = 200;                   // cycles per wait
    localparam int TFT_BUSY = 1 + 2 * TFT_BITS + 2;  // strobe, two per bit, setup and hold

    logic      clk;
    logic      nrst;
    cpu_req_s  cpu_req;
    logic      esp_wr;
    reg_addr_t esp_addr;
    word_t     esp_data;
    cpu_rsp_s  cpu_rsp;
    logic      tft_sclk;
    logic      tft_mosi;
    logic      tft_cs_n;
    int        busy_cycles;                          // busy samples of last request

    `include "mmio_model.svh"

    mmio_top u_mmio_top (
        .clk      (clk),
        .nrst     (nrst),
        .cpu_req  (cpu_req),
        .esp_wr   (esp_wr),
        .esp_addr (esp_addr),
        .esp_data (esp_data),
        .cpu_rsp  (cpu_rsp),
        .tft_sclk (tft_sclk),
        .tft_mosi (tft_mosi),
        .tft_cs_n (tft_cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                       // 8 ns period
    end

    always @(posedge clk) begin
        capture_tft(tft_sclk, tft_mosi, tft_cs_n);
    end

    task automatic start_request(input req_t rwi, input word_t addr, input word_t wdata);
        cpu_req.addr  <= addr;
        cpu_req.rwi   <= rwi;
        cpu_req.wdata <= wdata;
    endtask

    // busy is sampled at each rising edge and the low sample ends the request
    task automatic wait_not_busy();
        busy_cycles = 0;
        @(posedge clk);
        while (cpu_rsp.busy && busy_cycles < TIMEOUT) begin
            busy_cycles++;
            @(posedge clk);
        end
        if (cpu_rsp.busy) begin
            errors++;
            $display("Timeout at %0d ns: busy did not fall within %0d cycles", $time, TIMEOUT);
        end
    endtask

    task automatic finish_request();
        cpu_req.rwi <= req_idle;                     // one idle cycle between requests
        @(posedge clk);
    endtask

    task automatic cpu_access(input req_t rwi, input word_t addr, input word_t wdata,
                              output word_t rdata, output word_t instr);
        start_request(rwi, addr, wdata);
        wait_not_busy();
        rdata = cpu_rsp.rdata;                       // valid in the busy-low cycle
        instr = cpu_rsp.instr;
        finish_request();
    endtask

    task automatic report_test(input string name, input int chk0, input int err0);
        $display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        word_t     rdata;
        word_t     instr;
        word_t     addr;
        word_t     data;
        reg_addr_t ra;
        int        idx;
        int        hold;
        int        chk0;
        int        err0;
        word_t     store_addrs [$];
        int        fetch_idx [$];

        nrst     = 1'b0;
        cpu_req  = '0;                               // idle request
        esp_wr   = 1'b0;
        esp_addr = '0;
        esp_data = '0;
        void'($urandom(32'h6a4d_83a1));
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;                       // bank clears at reset
        end
        repeat (8) @(posedge clk);
        nrst <= 1'b1;

        chk0 = checks;
        err0 = errors;
        @(posedge clk);
        check_value("cpu_rsp.busy", 32'd0, word_t'(cpu_rsp.busy));
        check_value("tft_cs_n", 32'd1, word_t'(tft_cs_n));
        report_test("reset state", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 200; i++) begin
            addr = $urandom_range(DATA_TOP, REG_TOP + 1);
            data = $urandom();
            cpu_access(req_write, addr, data, rdata, instr);
            check_value("store busy cycles", SRAM_LAT + 1, busy_cycles);
            sram_model[addr[9:2]] = data;
            store_addrs.push_back(addr);
        end
        for (int i = 0; i < 200; i++) begin
            addr = store_addrs[$urandom_range(store_addrs.size() - 1, 0)];
            cpu_access(req_read, addr, '0, rdata, instr);
            check_value("load busy cycles", SRAM_LAT + 1, busy_cycles);
            check_value("cpu_rsp.rdata", expected_load(addr), rdata);
        end
        report_test("data store/load", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 32; i++) begin
            idx  = $urandom_range(192, 9);           // indices the data window can reach
            data = $urandom();
            cpu_access(req_write, 32'h400 + idx * 4, data, rdata, instr);
            sram_model[idx] = data;
            fetch_idx.push_back(idx);
        end
        for (int i = 0; i < 64; i++) begin
            idx  = fetch_idx[$urandom_range(fetch_idx.size() - 1, 0)];
            addr = idx * 4 + $urandom_range(3, 0);
            cpu_access(req_fetch, addr, '0, rdata, instr);
            check_value("fetch busy cycles", SRAM_LAT + 1, busy_cycles);
            check_value("cpu_rsp.instr", expected_load(addr), instr);
        end
        report_test("fetch via data alias", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            ra   = reg_addr_t'($urandom_range(31, 0));
            data = $urandom();
            esp_wr   <= 1'b1;
            esp_addr <= ra;
            esp_data <= data;
            reg_model[ra] = data;
            @(posedge clk);
        end
        esp_wr <= 1'b0;
        @(posedge clk);
        for (int a = INSTR_TOP + 1; a <= REG_TOP; a++) begin
            cpu_access(req_read, a, '0, rdata, instr);
            check_value("register busy cycles", 32'd1, busy_cycles);
            check_value("cpu_rsp.rdata", expected_reg(a), rdata);
        end
        report_test("esp32 register read", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            addr = $urandom_range(REG_TOP, INSTR_TOP + 1);
            ra   = addr[4:0];
            data = $urandom();
            hold = $urandom_range(6, 2);
            esp_wr   <= 1'b1;                        // esp write overlaps the read
            esp_addr <= ra;
            esp_data <= data;
            reg_model[ra] = data;
            start_request(req_read, addr, '0);
            for (int c = 0; c < hold; c++) begin
                @(posedge clk);
                check_value("busy during esp_wr", 32'd1, word_t'(cpu_rsp.busy));
            end
            esp_wr <= 1'b0;
            wait_not_busy();
            check_value("busy after esp_wr drop", 32'd1, busy_cycles);
            check_value("cpu_rsp.rdata", expected_reg(addr), cpu_rsp.rdata);
            finish_request();
        end
        report_test("register read during esp write", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            addr = $urandom_range(TFT_TOP, DATA_TOP + 1);
            data = $urandom();
            cpu_access(req_write, addr, data, rdata, instr);
            check_value("tft busy cycles", TFT_BUSY, busy_cycles);
            check_value("tft_cs_n", 32'd1, word_t'(tft_cs_n));
            if (tft_frames.size() == 0) begin
                checks++;
                errors++;
                $display("Missing TFT frame at %0d ns for data %h", $time, data);
            end else begin
                check_value("tft frame", data, tft_frames.pop_front());
            end
        end
        report_test("tft frames", chk0, err0);

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
